// ==== verilog/sqrt_config.svh ====
`ifndef SQRT_CONFIG_SVH
`define SQRT_CONFIG_SVH

// Operand format.
`define FP_WIDTH            32
`define EXP_WIDTH           8
`define MAN_WIDTH           23

// Added to the upper seven exponent bits.
`define EXP_HALF_BIAS_ODD   8'd64
`define EXP_HALF_BIAS_EVEN  8'd63

// Mantissa datapath.
`define SEED_INDEX_WIDTH    8
`define SEED_WIDTH          25
`define WORK_WIDTH          28
`define ROOT_WIDTH          24

`define SQRT_LATENCY        5

// Special encodings.
`define EXP_ALL_ONES        8'hFF
`define POS_INF_BITS        32'h7F80_0000

`endif

// ==== verilog/sqrt_pkg.sv ====
`include "sqrt_config.svh"

package sqrt_pkg;

	// Class information of one operand, carried alongside the mantissa path.
	typedef struct packed {
		logic [`EXP_WIDTH-1:0] exponent;
		logic                  zero;
		logic                  minus;
		logic                  inf;
	} sqrt_class_t;

	// Mantissa radicand B, value B / 2**23 in [1,4).
	typedef logic [`SEED_WIDTH-1:0] radicand_t;

	// Root with hidden bit, value root / 2**23 in [1,2).
	typedef logic [`ROOT_WIDTH-1:0] root_t;

endpackage

// ==== verilog/seed_rom.sv ====
`timescale 1ns/10ps
`include "sqrt_config.svh"

module seed_rom
	import sqrt_pkg::*;
(
	input  logic [`SEED_INDEX_WIDTH-1:0] index,
	output radicand_t                    seed,
	output radicand_t                    seed_half_cube
);

	localparam int TABLE_SIZE = 1 << `SEED_INDEX_WIDTH;
	localparam int HALF_SIZE  = TABLE_SIZE / 2;
	localparam int MAN_W      = `MAN_WIDTH;
	// Weight of the lowest mantissa bit in the index.
	localparam int STEP_SHIFT = MAN_W - `SEED_INDEX_WIDTH + 1;

	// Wide enough for 2**(3*MAN_W).
	typedef logic [79:0] wide_t;

	function automatic wide_t isqrt(input wide_t n);
		wide_t rem;
		wide_t res;
		wide_t one;
		rem = n;
		res = '0;
		for (int k = $bits(wide_t) / 2 - 1; k >= 0; k--) begin
			one = wide_t'(1) << (2 * k);
			if (rem >= res + one) begin
				rem = rem - (res + one);
				res = (res >> 1) + one;
			end else begin
				res = res >> 1;
			end
		end
		return res;
	endfunction

	// Left end of the interval of B that an index covers times 2**MAN_W.
	function automatic wide_t interval_left(input int idx);
		int    frac;
		wide_t left;
		frac = idx % HALF_SIZE;
		if (idx >= HALF_SIZE) begin
			// B in [1,2).
			left = (wide_t'(1) << MAN_W) + (wide_t'(frac) << STEP_SHIFT);
		end else begin
			// B in [2,4) with two entries per interval.
			frac = frac - (frac % 2);
			left = (wide_t'(1) << (MAN_W + 1)) + (wide_t'(frac) << (STEP_SHIFT + 1));
		end
		return left;
	endfunction

	// z = 1/sqrt(b) as sqrt(2**69 / B).
	function automatic radicand_t seed_value(input int idx);
		return radicand_t'(isqrt((wide_t'(1) << (3 * MAN_W)) / interval_left(idx)));
	endfunction

	function automatic radicand_t half_cube_value(input int idx);
		wide_t z;
		z = wide_t'(seed_value(idx));
		return radicand_t'((z * z * z) >> (2 * MAN_W + 1));
	endfunction

	radicand_t seed_tab [TABLE_SIZE];
	radicand_t cube_tab [TABLE_SIZE];

	for (genvar i = 0; i < TABLE_SIZE; i++) begin : g_entry
		localparam radicand_t SEED_VAL = seed_value(i);
		localparam radicand_t CUBE_VAL = half_cube_value(i);
		assign seed_tab[i] = SEED_VAL;
		assign cube_tab[i] = CUBE_VAL;
	end

	assign seed           = seed_tab[index];
	assign seed_half_cube = cube_tab[index];

endmodule

// ==== verilog/stage_delay.sv ====
`timescale 1ns/10ps

module stage_delay #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t in_data,
	output payload_t out_data
);

	payload_t pipe [DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0] <= in_data;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign out_data = pipe[DEPTH-1];

endmodule

// ==== verilog/special_class.sv ====
`timescale 1ns/10ps
`include "sqrt_config.svh"

module special_class
	import sqrt_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`FP_WIDTH-1:0] operand,
	output sqrt_class_t          cls
);

	logic [`EXP_WIDTH-1:0] exp_field;
	sqrt_class_t           cls_now;

	assign exp_field = operand[`FP_WIDTH-2 -: `EXP_WIDTH];

	always_comb begin
		// Denormals count as zero, NaN as infinity.
		cls_now.zero  = (exp_field == '0);
		cls_now.minus = operand[`FP_WIDTH-1];
		cls_now.inf   = (exp_field == `EXP_ALL_ONES);
		// An even biased exponent lent one bit to the radicand.
		if (exp_field[0]) begin
			cls_now.exponent = {1'b0, exp_field[`EXP_WIDTH-1:1]} + `EXP_HALF_BIAS_ODD;
		end else begin
			cls_now.exponent = {1'b0, exp_field[`EXP_WIDTH-1:1]} + `EXP_HALF_BIAS_EVEN;
		end
	end

	stage_delay #(
		.payload_t (sqrt_class_t),
		.DEPTH     (`SQRT_LATENCY - 1)
	) class_delay_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (cls_now),
		.out_data (cls)
	);

endmodule

// ==== verilog/newton_root.sv ====
`timescale 1ns/10ps
`include "sqrt_config.svh"

module newton_root
	import sqrt_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`FP_WIDTH-1:0] operand,
	output root_t                root
);

	localparam int MAN_W   = `MAN_WIDTH;
	localparam int SEED_W  = `SEED_WIDTH;
	localparam int WORK_W  = `WORK_WIDTH;
	localparam int ROOT_W  = `ROOT_WIDTH;
	// Working values are unsigned with two integer bits.
	localparam int FRAC_W  = WORK_W - 2;
	localparam int GUARD_W = FRAC_W - MAN_W;
	localparam int EST_W   = ROOT_W + 1;
	localparam int CMP_W   = 2 * EST_W + 1;
	localparam logic [WORK_W-1:0] THREE = WORK_W'(3) << FRAC_W;

	radicand_t                radicand;
	radicand_t                seed;
	radicand_t                seed_half_cube;
	logic [2*SEED_W-1:0]      bh_prod;
	logic [WORK_W-1:0]        x1_next;
	logic [WORK_W+SEED_W-1:0] xb_prod;
	logic [2*WORK_W-1:0]      xy_prod;
	logic [2*WORK_W-1:0]      yt_prod;

	logic [WORK_W-1:0]        x1_s1;
	radicand_t                rad_s1;
	logic [WORK_W-1:0]        x1_s2;
	logic [WORK_W-1:0]        y1_s2;
	radicand_t                rad_s2;
	logic [WORK_W-1:0]        y1_s3;
	logic [WORK_W-1:0]        t0_s3;
	radicand_t                rad_s3;
	logic [WORK_W-1:0]        t_s4;
	radicand_t                rad_s4;

	logic [EST_W-1:0]         r_est;
	logic [CMP_W-1:0]         r_sq;
	logic [CMP_W-1:0]         target;
	logic [EST_W-1:0]         r_adj;

	////////////////////////////////////////////////////////////
	// Seed lookup and first reciprocal-root step.
	////////////////////////////////////////////////////////////

	always_comb begin
		if (operand[MAN_W]) begin
			radicand = {2'b01, operand[MAN_W-1:0]};
		end else begin
			radicand = {1'b1, operand[MAN_W-1:0], 1'b0};
		end
	end

	seed_rom seed_rom_inst (
		.index          (operand[MAN_W -: `SEED_INDEX_WIDTH]),
		.seed           (seed),
		.seed_half_cube (seed_half_cube)
	);

	// x1 = 1.5*z - B*z^3/2
	assign bh_prod = radicand * seed_half_cube;
	assign x1_next = (WORK_W'(seed) << GUARD_W) + (WORK_W'(seed) << (GUARD_W - 1))
		- WORK_W'(bh_prod >> (2 * MAN_W - FRAC_W));

	// Root estimate, then the coupled step t = y1 * (3 - x1*y1) / 2.
	assign xb_prod = x1_s1 * rad_s1;
	assign xy_prod = x1_s2 * y1_s2;
	assign yt_prod = y1_s3 * t0_s3;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x1_s1  <= '0;
			rad_s1 <= '0;
			x1_s2  <= '0;
			y1_s2  <= '0;
			rad_s2 <= '0;
			y1_s3  <= '0;
			t0_s3  <= '0;
			rad_s3 <= '0;
			t_s4   <= '0;
			rad_s4 <= '0;
		end else begin
			x1_s1  <= x1_next;
			rad_s1 <= radicand;
			x1_s2  <= x1_s1;
			y1_s2  <= WORK_W'(xb_prod >> MAN_W);
			rad_s2 <= rad_s1;
			y1_s3  <= y1_s2;
			t0_s3  <= THREE - WORK_W'(xy_prod >> FRAC_W);
			rad_s3 <= rad_s2;
			t_s4   <= WORK_W'(yt_prod >> (FRAC_W + 1));
			rad_s4 <= rad_s3;
		end
	end

	////////////////////////////////////////////////////////////
	// Nearest correction.
	////////////////////////////////////////////////////////////

	assign r_est  = EST_W'(t_s4 >> GUARD_W) + EST_W'(t_s4[GUARD_W-1]);
	assign r_sq   = CMP_W'(r_est) * CMP_W'(r_est);
	assign target = CMP_W'(rad_s4) << MAN_W;

	// R is nearest when R^2 - R < B*2^23 <= R^2 + R.
	always_comb begin
		if (target <= r_sq - CMP_W'(r_est)) begin
			r_adj = r_est - 1'b1;
		end else if (target > r_sq + CMP_W'(r_est)) begin
			r_adj = r_est + 1'b1;
		end else begin
			r_adj = r_est;
		end
	end

	assign root = ROOT_W'(r_adj);

endmodule

// ==== verilog/result_pack.sv ====
`timescale 1ns/10ps
`include "sqrt_config.svh"

module result_pack
	import sqrt_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 valid_late,
	input  sqrt_class_t          cls,
	input  root_t                root,
	output logic                 result_valid,
	output logic [`FP_WIDTH-1:0] result,
	output logic                 invalid
);

	logic [`FP_WIDTH-1:0] result_next;
	logic                 invalid_next;

	// Zero wins over the sign, the sign over infinity and NaN.
	always_comb begin
		if (cls.zero || cls.minus) begin
			result_next = '0;
		end else if (cls.inf) begin
			result_next = `POS_INF_BITS;
		end else begin
			result_next = {1'b0, cls.exponent, root[`MAN_WIDTH-1:0]};
		end
	end

	assign invalid_next = (cls.minus | cls.inf) & ~cls.zero;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			result       <= '0;
			invalid      <= 1'b0;
		end else begin
			result_valid <= valid_late;
			// Held until the next operand comes out.
			if (valid_late) begin
				result  <= result_next;
				invalid <= invalid_next;
			end
		end
	end

endmodule

// ==== verilog/sqrt_top.sv ====
`timescale 1ns/10ps
`include "sqrt_config.svh"

module sqrt_top
	import sqrt_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 op_valid,
	input  logic [`FP_WIDTH-1:0] operand,
	output logic                 result_valid,
	output logic [`FP_WIDTH-1:0] result,
	output logic                 invalid
);

	root_t       root;
	sqrt_class_t cls;
	logic        valid_late;

	newton_root newton_root_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.operand (operand),
		.root    (root)
	);

	special_class special_class_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.operand (operand),
		.cls     (cls)
	);

	// Valid follows the same depth as the two data paths.
	stage_delay #(
		.payload_t (logic),
		.DEPTH     (`SQRT_LATENCY - 1)
	) valid_delay_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (op_valid),
		.out_data (valid_late)
	);

	result_pack result_pack_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid_late   (valid_late),
		.cls          (cls),
		.root         (root),
		.result_valid (result_valid),
		.result       (result),
		.invalid      (invalid)
	);

endmodule

// ==== dv/sqrt_tb.sv ====
`timescale 1ns/10ps
`include "sqrt_config.svh"

module sqrt_tb;

	localparam int CLK_PERIOD      = 8;
	localparam int N_RANDOM        = 1000;
	localparam int N_FIXED         = 32;
	// Each operand takes at most four cycles including its gap.
	localparam int WATCHDOG_CYCLES = (N_FIXED + 2 * N_RANDOM) * 4 + 200;

	logic                 clk;
	logic                 rst_n;
	logic                 op_valid;
	logic [`FP_WIDTH-1:0] operand;
	logic                 result_valid;
	logic [`FP_WIDTH-1:0] result;
	logic                 invalid;

	logic [15:0]          lfsr;
	int                   edge_count;
	logic [31:0]          exp_result_q [$];
	logic                 exp_invalid_q [$];
	int                   exp_edge_q [$];
	logic [31:0]          last_result;
	logic                 last_invalid;

	sqrt_top sqrt_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_valid     (op_valid),
		.operand      (operand),
		.result_valid (result_valid),
		.result       (result),
		.invalid      (invalid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	////////////////////////////////////////////////////////////
	// Helpers.
	////////////////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Returns {invalid, result} for one operand.
	function automatic logic [32:0] sqrt_ref(input logic [31:0] op);
		logic [7:0]  e;
		logic [7:0]  half_exp;
		logic [24:0] b;
		logic [63:0] n;
		logic [63:0] r;
		logic [63:0] trial;
		e = op[30:23];
		if (e == 8'h00) begin
			return {1'b0, 32'h0000_0000};
		end
		if (op[31]) begin
			return {1'b1, 32'h0000_0000};
		end
		if (e == 8'hFF) begin
			return {1'b1, 32'h7F80_0000};
		end
		if (e[0]) begin
			b        = {2'b01, op[22:0]};
			half_exp = (e >> 1) + 8'd64;
		end else begin
			b        = {1'b1, op[22:0], 1'b0};
			half_exp = (e >> 1) + 8'd63;
		end
		n = {39'd0, b} << 23;
		// Floor root with one result bit per step.
		r = '0;
		for (int k = 24; k >= 0; k--) begin
			trial = r | (64'd1 << k);
			if (trial * trial <= n) begin
				r = trial;
			end
		end
		// Round up when n lies past (r + 1/2)^2.
		if (n - r * r > r) begin
			r = r + 64'd1;
		end
		return {1'b0, 1'b0, half_exp, r[22:0]};
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Result appears SQRT_LATENCY edges after the edge that drives op_valid.
	task automatic issue(input logic [31:0] op, input logic [31:0] exp_res,
		input logic exp_inv, input int gap);
		@(posedge clk);
		op_valid <= 1'b1;
		operand  <= op;
		exp_result_q.push_back(exp_res);
		exp_invalid_q.push_back(exp_inv);
		exp_edge_q.push_back(edge_count + 1 + `SQRT_LATENCY);
		for (int i = 0; i < gap; i++) begin
			@(posedge clk);
			op_valid <= 1'b0;
			operand  <= ~op;
		end
	endtask

	task automatic issue_ref(input logic [31:0] op, input int gap);
		logic [32:0] expected;
		expected = sqrt_ref(op);
		issue(op, expected[31:0], expected[32], gap);
	endtask

	task automatic issue_random(input int gap);
		logic [31:0] r;
		logic [31:0] m;
		logic [7:0]  e;
		random_bits(8, r);
		e = 8'(1 + (r % 254));
		random_bits(23, m);
		issue_ref({1'b0, e, m[22:0]}, gap);
	endtask

	////////////////////////////////////////////////////////////
	// Checker and watchdog.
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n) begin
			if (result_valid && exp_result_q.size() == 0) begin
				$display("result_valid pulsed with no operand outstanding at %0t", $time);
				$display("tests failed");
				$fatal(1);
			end else if (result_valid) begin
				compare("result", result, exp_result_q.pop_front());
				compare("invalid", 32'(invalid), 32'(exp_invalid_q.pop_front()));
				compare("result_valid edge", edge_count, exp_edge_q.pop_front());
				last_result  = result;
				last_invalid = invalid;
			end else begin
				compare("result", result, last_result);
				compare("invalid", 32'(invalid), 32'(last_invalid));
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all results came out");
		$display("tests failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// Stimulus.
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] g;
		clk          = 1'b0;
		rst_n        = 1'b0;
		op_valid     = 1'b0;
		operand      = '0;
		lfsr         = 16'd63;
		edge_count   = 0;
		last_result  = '0;
		last_invalid = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		compare("result_valid", 32'(result_valid), 32'd0);
		compare("result", result, 32'd0);
		compare("invalid", 32'(invalid), 32'd0);

		// Exact squares.
		issue(32'h4080_0000, 32'h4000_0000, 1'b0, 0);
		issue(32'h4110_0000, 32'h4040_0000, 1'b0, 0);
		issue(32'h3E80_0000, 32'h3F00_0000, 1'b0, 1);
		issue(32'h3F80_0000, 32'h3F80_0000, 1'b0, 2);

		// Zero and denormals.
		issue(32'h0000_0000, 32'h0000_0000, 1'b0, 0);
		issue(32'h8000_0000, 32'h0000_0000, 1'b0, 0);
		issue(32'h0000_0001, 32'h0000_0000, 1'b0, 1);
		issue(32'h007F_FFFF, 32'h0000_0000, 1'b0, 0);
		issue(32'h8040_0000, 32'h0000_0000, 1'b0, 0);

		// Negative nonzero operands.
		issue(32'hBF80_0000, 32'h0000_0000, 1'b1, 0);
		issue(32'hC120_0000, 32'h0000_0000, 1'b1, 2);
		issue(32'h8080_0000, 32'h0000_0000, 1'b1, 0);
		issue(32'hFF80_0000, 32'h0000_0000, 1'b1, 0);
		issue(32'hFFC0_0000, 32'h0000_0000, 1'b1, 1);

		// Infinity and NaN.
		issue(32'h7F80_0000, 32'h7F80_0000, 1'b1, 0);
		issue(32'h7FC0_0000, 32'h7F80_0000, 1'b1, 0);
		issue(32'h7F80_0001, 32'h7F80_0000, 1'b1, 3);

		// Range ends.
		issue_ref(32'h0080_0000, 0);
		issue_ref(32'h7F7F_FFFF, 0);
		issue_ref(32'h3FFF_FFFF, 1);

		// Back to back and then with random gaps.
		for (int i = 0; i < N_RANDOM; i++) begin
			issue_random(0);
		end
		for (int i = 0; i < N_RANDOM; i++) begin
			random_bits(2, g);
			issue_random(int'(g));
		end

		@(posedge clk);
		op_valid <= 1'b0;
		while (exp_result_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/sqrt_pkg.sv
verilog/seed_rom.sv
verilog/stage_delay.sv
verilog/special_class.sv
verilog/newton_root.sv
verilog/result_pack.sv
verilog/sqrt_top.sv
dv/sqrt_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module sqrt_tb \
	-Mdir obj_dir -o sqrt_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sqrt_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "SIMULATION FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "SIMULATION DID NOT FINISH"; exit 1; }
echo "SIMULATION PASSED"
